/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
TOP        ?= dz_timer_tb
FILELIST   ?= dz_timer_top.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "FAIL: run did not complete"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dz_timer_top.f */
+incdir+logic
logic/dz_ctrl_pkg.sv
logic/dz_disp_pkg.sv
logic/dz_cmd_decode.sv
logic/dz_countdown.sv
logic/dz_show.sv
logic/dz_timer_top.sv
sim/dz_timer_tb.sv

/* logic/dz_cmd_decode.sv */
`timescale 1ns/100ps

module dz_cmd_decode
    import dz_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  logic    stop,
    input  logic    tick,
    output dz_cmd_e cmd
);

    // Start beats stop, and stop beats tick.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cmd <= CMD_NONE;
        end
        else if (start)
        begin
            cmd <= CMD_START;
        end
        else if (stop)
        begin
            cmd <= CMD_STOP;
        end
        else if (tick)
        begin
            cmd <= CMD_TICK;
        end
        else
        begin
            cmd <= CMD_NONE;
        end
    end

    // A command never outlives its pulse.
    a_cmd_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        !(start || stop || tick) |=> (cmd == CMD_NONE)
    );

endmodule

/* logic/dz_countdown.sv */
`timescale 1ns/100ps

`include "dz_macros.svh"

module dz_countdown
    import dz_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  dz_cmd_e   cmd,
    output dz_digit_t digit
);

    // ==============================
    // Countdown FSM
    // ==============================

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit.state <= ST_IDLE;
            digit.digit <= 3'd0;
        end
        else
        begin
            case (cmd)
                CMD_START:
                begin
                    digit.state <= ST_RUN;
                    digit.digit <= 3'(`DZ_START_DIGIT);
                end
                CMD_STOP:
                begin
                    digit.state <= ST_IDLE;
                    digit.digit <= 3'd0;
                end
                CMD_TICK:
                begin
                    // Idle and done ignore the tick.
                    if (digit.state == ST_RUN)
                    begin
                        digit.digit <= digit.digit - 3'd1;
                        if (digit.digit == 3'd1)
                        begin
                            digit.state <= ST_DONE;
                        end
                    end
                end
                default:
                begin
                    digit <= digit;
                end
            endcase
        end
    end

    // ==============================
    // Checks
    // ==============================

    a_digit_range: assert property (
        @(posedge clk) disable iff (rst)
        digit.digit <= 3'(`DZ_START_DIGIT)
    );

    a_done_zero: assert property (
        @(posedge clk) disable iff (rst)
        (digit.state == ST_DONE) |-> (digit.digit == 3'd0)
    );

    a_idle_zero: assert property (
        @(posedge clk) disable iff (rst)
        (digit.state == ST_IDLE) |-> (digit.digit == 3'd0)
    );

endmodule

/* logic/dz_ctrl_pkg.sv */
package dz_ctrl_pkg;

    // One command per cycle leaves the decode register.
    typedef enum logic [1:0]
    {
        CMD_NONE  = 2'd0,
        CMD_START = 2'd1,
        CMD_STOP  = 2'd2,
        CMD_TICK  = 2'd3
    } dz_cmd_e;

    typedef enum logic [1:0]
    {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } dz_state_e;

    // Countdown record handed from the state machine to the display.
    typedef struct packed
    {
        dz_state_e  state;
        logic [2:0] digit;
    } dz_digit_t;

endpackage

/* logic/dz_disp_pkg.sv */
package dz_disp_pkg;

`include "dz_macros.svh"

    // Yellow lights both the red and the green LED of a dot.
    typedef enum logic [1:0]
    {
        COL_OFF    = 2'd0,
        COL_RED    = 2'd1,
        COL_GREEN  = 2'd2,
        COL_YELLOW = 2'd3
    } dz_color_e;

    // One scanned row of the matrix as it leaves the output register.
    typedef struct packed
    {
        logic [`DZ_ROWS-1:0] row;
        logic [`DZ_COLS-1:0] colr;
        logic [`DZ_COLS-1:0] colg;
    } dz_row_t;

endpackage

/* logic/dz_macros.svh */
`ifndef DZ_MACROS_SVH
`define DZ_MACROS_SVH

// Digit loaded by a start pulse.
`define DZ_START_DIGIT 5

// Dot matrix size.
`define DZ_ROWS 8
`define DZ_COLS 8

`endif

/* logic/dz_show.sv */
`timescale 1ns/100ps

`include "dz_macros.svh"

module dz_show
    import dz_ctrl_pkg::*, dz_disp_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  dz_digit_t           digit,
    output logic [`DZ_ROWS-1:0] row,
    output logic [`DZ_COLS-1:0] colr,
    output logic [`DZ_COLS-1:0] colg
);

    localparam int SCAN_W = $clog2(`DZ_ROWS);

    dz_digit_t           dig_q;
    logic [SCAN_W-1:0]   scan;
    dz_color_e           color;
    logic [`DZ_COLS-1:0] glyph;
    logic [`DZ_ROWS-1:0] row_next;
    dz_row_t             out_q;

    // Glyph bitmaps packed with row 7 in the top byte; row 0 stays blank.
    function automatic logic [`DZ_COLS-1:0] glyph_byte(
        input logic [2:0]        d,
        input logic [SCAN_W-1:0] r
    );
        logic [`DZ_ROWS*`DZ_COLS-1:0] rows;
        case (d)
            3'd5:    rows = 64'h3C66_0606_7C60_7E00;
            3'd4:    rows = 64'h0C0C_7E4C_2C1C_0C00;
            3'd3:    rows = 64'h3C66_061C_0666_3C00;
            3'd2:    rows = 64'h7E30_180C_0666_3C00;
            3'd1:    rows = 64'h3C18_1818_1838_1800;
            3'd0:    rows = 64'h3C66_6676_6E66_3C00;
            default: rows = '0;
        endcase
        return rows[r*`DZ_COLS +: `DZ_COLS];
    endfunction

    // ==============================
    // Digit and scan registers
    // ==============================

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dig_q.state <= ST_IDLE;
            dig_q.digit <= 3'd0;
        end
        else
        begin
            dig_q <= digit;
        end
    end

    // Starts at 1 because the output register already holds row 0 out of reset.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan <= SCAN_W'(1);
        end
        else if (scan == SCAN_W'(`DZ_ROWS - 1))
        begin
            scan <= '0;
        end
        else
        begin
            scan <= scan + SCAN_W'(1);
        end
    end

    // ==============================
    // Colour and glyph lookup
    // ==============================

    always_comb
    begin
        if (dig_q.state == ST_IDLE)
        begin
            color = COL_OFF;
        end
        else if (dig_q.digit >= 3'd4)
        begin
            color = COL_RED;
        end
        else if (dig_q.digit != 3'd0)
        begin
            color = COL_GREEN;
        end
        else
        begin
            color = COL_YELLOW;
        end
    end

    assign glyph = glyph_byte(dig_q.digit, scan);

    always_comb
    begin
        row_next = '0;
        row_next[scan] = 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            out_q.row  <= `DZ_ROWS'(1);
            out_q.colr <= '0;
            out_q.colg <= '0;
        end
        else
        begin
            out_q.row  <= row_next;
            out_q.colr <= (color == COL_RED || color == COL_YELLOW) ? glyph : '0;
            out_q.colg <= (color == COL_GREEN || color == COL_YELLOW) ? glyph : '0;
        end
    end

    assign row  = out_q.row;
    assign colr = out_q.colr;
    assign colg = out_q.colg;

    a_row_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot(row)
    );

    // A count that has just entered the run state begins at the start digit.
    a_start_red: assert property (
        @(posedge clk) disable iff (rst)
        (dig_q.state == ST_RUN && $past(dig_q.state) != ST_RUN)
            |-> (dig_q.digit == 3'(`DZ_START_DIGIT))
    );

    // Zero is only ever shown once the count has finished.
    a_yellow_both: assert property (
        @(posedge clk) disable iff (rst)
        (color == COL_YELLOW) |-> (dig_q.state == ST_DONE)
    );

endmodule

/* logic/dz_timer_top.sv */
`timescale 1ns/100ps

`include "dz_macros.svh"

module dz_timer_top
    import dz_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                stop,
    input  logic                tick,
    output logic [`DZ_ROWS-1:0] row,
    output logic [`DZ_COLS-1:0] colr,
    output logic [`DZ_COLS-1:0] colg
);

    dz_cmd_e   cmd;
    dz_digit_t digit;

    dz_cmd_decode u_decode (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .stop  (stop),
        .tick  (tick),
        .cmd   (cmd)
    );

    dz_countdown u_countdown (
        .clk   (clk),
        .rst   (rst),
        .cmd   (cmd),
        .digit (digit)
    );

    dz_show u_show (
        .clk   (clk),
        .rst   (rst),
        .digit (digit),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

endmodule

/* sim/dz_timer_tb.sv */
`timescale 1ns/100ps

`include "dz_macros.svh"

module dz_timer_tb;

    localparam string TRACE_FILE = "sim/dz_timer_trace.txt";
    localparam int    MAX_STEPS  = 64;

    logic                clk = 1'b0;
    logic                rst;
    logic                start;
    logic                stop;
    logic                tick;
    logic [`DZ_ROWS-1:0] row;
    logic [`DZ_COLS-1:0] colr;
    logic [`DZ_COLS-1:0] colg;

    logic                step_start [MAX_STEPS];
    logic                step_stop  [MAX_STEPS];
    logic                step_tick  [MAX_STEPS];
    int                  step_count [MAX_STEPS];
    logic [`DZ_COLS-1:0] step_red   [MAX_STEPS][`DZ_ROWS];
    logic [`DZ_COLS-1:0] step_green [MAX_STEPS][`DZ_ROWS];

    int num_steps   = 0;
    int errors      = 0;
    int cycle_count = 0;
    int cycle_limit = 50;

    dz_timer_top i_dut (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .stop  (stop),
        .tick  (tick),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

    always #4 clk = ~clk;

    // ==============================
    // Checks and trace loading
    // ==============================

    task automatic check_value(
        input logic [7:0] actual,
        input logic [7:0] expected,
        input string      what
    );
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    code;
        int    p_start;
        int    p_stop;
        int    p_tick;
        int    p_count;
        string line;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the trace file %s", TRACE_FILE);
            errors++;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.substr(0, 0) != "#" && num_steps < MAX_STEPS)
                begin
                    code = $sscanf(line,
                        "%d %d %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        p_start, p_stop, p_tick, p_count,
                        step_red[num_steps][0], step_red[num_steps][1],
                        step_red[num_steps][2], step_red[num_steps][3],
                        step_red[num_steps][4], step_red[num_steps][5],
                        step_red[num_steps][6], step_red[num_steps][7],
                        step_green[num_steps][0], step_green[num_steps][1],
                        step_green[num_steps][2], step_green[num_steps][3],
                        step_green[num_steps][4], step_green[num_steps][5],
                        step_green[num_steps][6], step_green[num_steps][7]);
                    if (code == 20)
                    begin
                        step_start[num_steps] = (p_start != 0);
                        step_stop[num_steps]  = (p_stop != 0);
                        step_tick[num_steps]  = (p_tick != 0);
                        step_count[num_steps] = p_count;
                        num_steps++;
                    end
                    else if (code > 0)
                    begin
                        $display("Trace line %0d is incomplete: %s", num_steps, line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
            if (num_steps == 0)
            begin
                $display("The trace file holds no test steps");
                errors++;
            end
        end
        cycle_limit = 20 * num_steps + 50;
    endtask

    // ==============================
    // One trace step
    // ==============================

    task automatic run_step(input int s);
        logic [`DZ_ROWS-1:0] seen;
        int                  idx;
        int                  k;
        int                  c;
        int                  j;
        seen = '0;
        idx  = 0;
        // A count above one repeats the pulses on back-to-back cycles.
        for (k = 0; k < step_count[s]; k++)
        begin
            @(posedge clk);
            #1;
            start = step_start[s];
            stop  = step_stop[s];
            tick  = step_tick[s];
        end
        @(posedge clk);
        #1;
        start = 1'b0;
        stop  = 1'b0;
        tick  = 1'b0;
        repeat (6) @(posedge clk);
        for (c = 0; c < `DZ_ROWS; c++)
        begin
            @(negedge clk);
            if (!$onehot(row))
            begin
                $display("Step %0d: row value %b is not one-hot at %0t ns", s, row, $time);
                errors++;
            end
            else
            begin
                for (j = 0; j < `DZ_ROWS; j++)
                begin
                    if (row[j])
                    begin
                        idx = j;
                    end
                end
                seen = seen | row;
                check_value(colr, step_red[s][idx], $sformatf("step %0d row %0d colr", s, idx));
                check_value(colg, step_green[s][idx], $sformatf("step %0d row %0d colg", s, idx));
            end
        end
        check_value(seen, {`DZ_ROWS{1'b1}}, $sformatf("step %0d rows scanned", s));
    endtask

    // ==============================
    // Main sequence and timeout
    // ==============================

    initial
    begin
        rst   = 1'b1;
        start = 1'b0;
        stop  = 1'b0;
        tick  = 1'b0;
        load_trace();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < num_steps; i++)
        begin
            run_step(i);
        end
        $display("Run complete: %0d errors over %0d steps", errors, num_steps);
        if (errors == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

/* sim/dz_timer_trace.txt */
# start stop tick count | red bytes for rows 0..7 | green bytes for rows 0..7
# count is the number of back-to-back cycles the pulses are held.
0 0 0 1  00 00 00 00 00 00 00 00  00 00 00 00 00 00 00 00
# Full countdown from 5 to 0, then a tick while done.
1 0 0 1  00 7E 60 7C 06 06 66 3C  00 00 00 00 00 00 00 00
0 0 1 1  00 0C 1C 2C 4C 7E 0C 0C  00 00 00 00 00 00 00 00
0 0 1 1  00 00 00 00 00 00 00 00  00 3C 66 06 1C 06 66 3C
0 0 1 1  00 00 00 00 00 00 00 00  00 3C 66 06 0C 18 30 7E
0 0 1 1  00 00 00 00 00 00 00 00  00 18 38 18 18 18 18 3C
0 0 1 1  00 3C 66 6E 76 66 66 3C  00 3C 66 6E 76 66 66 3C
0 0 1 1  00 3C 66 6E 76 66 66 3C  00 3C 66 6E 76 66 66 3C
# Stop from done, tick while idle, stop from run.
0 1 0 1  00 00 00 00 00 00 00 00  00 00 00 00 00 00 00 00
0 0 1 1  00 00 00 00 00 00 00 00  00 00 00 00 00 00 00 00
1 0 0 1  00 7E 60 7C 06 06 66 3C  00 00 00 00 00 00 00 00
0 0 1 1  00 0C 1C 2C 4C 7E 0C 0C  00 00 00 00 00 00 00 00
0 1 0 1  00 00 00 00 00 00 00 00  00 00 00 00 00 00 00 00
# Restart mid count, start and tick together, two ticks back to back.
1 0 0 1  00 7E 60 7C 06 06 66 3C  00 00 00 00 00 00 00 00
0 0 1 1  00 0C 1C 2C 4C 7E 0C 0C  00 00 00 00 00 00 00 00
1 0 0 1  00 7E 60 7C 06 06 66 3C  00 00 00 00 00 00 00 00
0 0 1 1  00 0C 1C 2C 4C 7E 0C 0C  00 00 00 00 00 00 00 00
1 0 1 1  00 7E 60 7C 06 06 66 3C  00 00 00 00 00 00 00 00
0 0 1 2  00 00 00 00 00 00 00 00  00 3C 66 06 1C 06 66 3C
0 1 0 1  00 00 00 00 00 00 00 00  00 00 00 00 00 00 00 00
